// ==== rtl/id_isa_pkg.sv ====
`default_nettype none

package id_isa_pkg;

  // Architectural register number width
  localparam int unsigned REG_W = 5;

  // Major opcodes seen by the decode stage
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;

  // funct7 shared by all M-extension ops
  localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

  // ADDI x0, x0, 0
  localparam logic [31:0] NOP_INSTR = 32'h0000_0013;

  // Register-register view of the word
  typedef struct packed {
    logic [6:0]       funct7;
    logic [REG_W-1:0] rs2;
    logic [REG_W-1:0] rs1;
    logic [2:0]       funct3;
    logic [REG_W-1:0] rd;
    logic [6:0]       opcode;
  } instr_r_t;

  // SYSTEM view, rs1 doubles as the CSR immediate
  typedef struct packed {
    logic [11:0]      csr;
    logic [REG_W-1:0] rs1;
    logic [2:0]       funct3;
    logic [REG_W-1:0] rd;
    logic [6:0]       opcode;
  } instr_sys_t;

  typedef union packed {
    instr_r_t   r;
    instr_sys_t sys;
  } instr_u;

  // Branch condition handed to EX
  typedef enum logic [2:0] {
    BR_NONE = 3'd0,
    BR_EQ   = 3'd1,
    BR_NE   = 3'd2,
    BR_LT   = 3'd3,
    BR_GE   = 3'd4,
    BR_LTU  = 3'd5,
    BR_GEU  = 3'd6
  } branch_op_e;

  // Store access size
  typedef enum logic [1:0] {
    ST_NONE = 2'd0,
    ST_BYTE = 2'd1,
    ST_HALF = 2'd2,
    ST_WORD = 2'd3
  } store_op_e;

endpackage

`default_nettype wire

// ==== rtl/id_pipe_pkg.sv ====
`default_nettype none

package id_pipe_pkg;

  // Decoded control bundle, one bit per instruction class
  typedef struct packed {
    logic                   is_load;
    logic                   is_load_byte;
    logic                   is_load_half;
    logic                   is_load_unsigned;
    logic                   is_mul;
    logic                   is_div;
    logic                   is_jal;
    logic                   is_jalr;
    logic                   is_csr;
    logic                   is_ecall;
    logic                   is_ebreak;
    logic                   is_mret;
    logic                   is_wfi;
    id_isa_pkg::branch_op_e branch_op;
    id_isa_pkg::store_op_e  store_op;
  } id_ctrl_t;

  // Bubble control, nothing active
  localparam id_ctrl_t CTRL_NOP = '{
    branch_op: id_isa_pkg::BR_NONE,
    store_op:  id_isa_pkg::ST_NONE,
    default:   1'b0
  };

  // All five immediate formats, already sign extended
  typedef struct packed {
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
  } id_imm_t;

endpackage

`default_nettype wire

// ==== rtl/id_decode_if.sv ====
`default_nettype none

interface id_decode_if #(
  parameter int unsigned XLEN = 32
);
  import id_pipe_pkg::*;

  // Control flags and codes
  id_ctrl_t        ctrl;
  // Immediates of every format
  id_imm_t         imm;
  // PC-relative targets
  logic [XLEN-1:0] branch_target;
  logic [XLEN-1:0] jal_target;

  modport producer (output ctrl, output imm, output branch_target, output jal_target);
  modport consumer (input ctrl, input imm, input branch_target, input jal_target);

endinterface

`default_nettype wire

// ==== rtl/id_operand_if.sv ====
`default_nettype none

interface id_operand_if #(
  parameter int unsigned XLEN = 32
);
  // Source data after write-back bypass
  logic [XLEN-1:0] rs1_data;
  logic [XLEN-1:0] rs2_data;
  // Source register is x0
  logic            rs1_is_x0;
  logic            rs2_is_x0;

  modport producer (output rs1_data, output rs2_data, output rs1_is_x0, output rs2_is_x0);
  modport consumer (input rs1_data, input rs2_data, input rs1_is_x0, input rs2_is_x0);

endinterface

`default_nettype wire

// ==== rtl/id_decoder.sv ====
`default_nettype none

module id_decoder #(
  parameter int unsigned XLEN = 32
) (
  input  id_isa_pkg::instr_u i_instr,
  input  logic [XLEN-1:0]    i_pc,
  id_decode_if.producer      dec
);
  import id_isa_pkg::*;
  import id_pipe_pkg::*;

  logic [31:0]      word;
  logic [6:0]       opcode;
  logic [2:0]       funct3;
  logic [6:0]       funct7;
  logic [REG_W-1:0] rs2;
  logic             is_m_ext;
  logic             is_priv;
  id_ctrl_t         ctrl;
  id_imm_t          imm;

  // Raw bits for immediate slicing
  assign word   = i_instr;
  // R view for ALU, load, store and privileged fields
  assign opcode = i_instr.r.opcode;
  assign funct3 = i_instr.r.funct3;
  assign funct7 = i_instr.r.funct7;
  assign rs2    = i_instr.r.rs2;

  assign is_m_ext = (opcode == OPC_OP) && (funct7 == FUNCT7_MULDIV);
  // ECALL, EBREAK, MRET and WFI share SYSTEM with funct3 000
  assign is_priv  = (opcode == OPC_SYSTEM) && (funct3 == 3'b000);

  always_comb begin
    ctrl = CTRL_NOP;

    // Load size from funct3, bit 2 marks LBU and LHU
    ctrl.is_load          = (opcode == OPC_LOAD);
    ctrl.is_load_byte     = ctrl.is_load && (funct3[1:0] == 2'b00);
    ctrl.is_load_half     = ctrl.is_load && (funct3[1:0] == 2'b01);
    ctrl.is_load_unsigned = ctrl.is_load && funct3[2];

    // MUL* have funct3[2] clear, DIV and REM have it set
    ctrl.is_mul = is_m_ext && !funct3[2];
    ctrl.is_div = is_m_ext && funct3[2];

    ctrl.is_jal  = (opcode == OPC_JAL);
    ctrl.is_jalr = (opcode == OPC_JALR) && (funct3 == 3'b000);

    // CSR ops use the SYS view, nonzero funct3 keeps them apart from privileged ops
    ctrl.is_csr = (i_instr.sys.opcode == OPC_SYSTEM) && (i_instr.sys.funct3 != 3'b000);

    // Privileged ops matched on funct7 and rs2
    ctrl.is_ecall  = is_priv && (funct7 == 7'b0000000) && (rs2 == 5'b00000);
    ctrl.is_ebreak = is_priv && (funct7 == 7'b0000000) && (rs2 == 5'b00001);
    ctrl.is_mret   = is_priv && (funct7 == 7'b0011000) && (rs2 == 5'b00010);
    ctrl.is_wfi    = is_priv && (funct7 == 7'b0001000) && (rs2 == 5'b00101);

    // Branch condition, 010 and 011 are reserved
    if (opcode == OPC_BRANCH) begin
      case (funct3)
        3'b000:  ctrl.branch_op = BR_EQ;
        3'b001:  ctrl.branch_op = BR_NE;
        3'b100:  ctrl.branch_op = BR_LT;
        3'b101:  ctrl.branch_op = BR_GE;
        3'b110:  ctrl.branch_op = BR_LTU;
        3'b111:  ctrl.branch_op = BR_GEU;
        default: ctrl.branch_op = BR_NONE;
      endcase
    end

    // Store size, only SB, SH and SW exist on RV32
    if (opcode == OPC_STORE) begin
      case (funct3)
        3'b000:  ctrl.store_op = ST_BYTE;
        3'b001:  ctrl.store_op = ST_HALF;
        3'b010:  ctrl.store_op = ST_WORD;
        default: ctrl.store_op = ST_NONE;
      endcase
    end
  end

  // I type, bits 31:20
  assign imm.imm_i = {{20{word[31]}}, word[31:20]};
  // S type, split around rd
  assign imm.imm_s = {{20{word[31]}}, word[31:25], word[11:7]};
  // B type, even offsets only
  assign imm.imm_b = {{19{word[31]}}, word[31], word[7], word[30:25], word[11:8], 1'b0};
  // U type, low 12 bits zero
  assign imm.imm_u = {word[31:12], 12'h000};
  // J type, 21-bit offset
  assign imm.imm_j = {{11{word[31]}}, word[31], word[19:12], word[20], word[30:21], 1'b0};

  assign dec.ctrl = ctrl;
  assign dec.imm  = imm;

  // Targets computed here so EX only needs the JALR adder
  assign dec.branch_target = i_pc + XLEN'(signed'(imm.imm_b));
  assign dec.jal_target    = i_pc + XLEN'(signed'(imm.imm_j));

  // EX issues to a single mul/div unit and a single load aligner
  always_comb begin
    assert final (!(ctrl.is_mul && ctrl.is_div))
      else $error("id_decoder: mul and div flagged together");
    assert final (!(ctrl.is_load_byte && ctrl.is_load_half))
      else $error("id_decoder: byte and halfword load flagged together");
  end

endmodule

`default_nettype wire

// ==== rtl/id_operand_bypass.sv ====
`default_nettype none

module id_operand_bypass #(
  parameter int unsigned XLEN = 32
) (
  input  logic [id_isa_pkg::REG_W-1:0] i_rs1_early,
  input  logic [id_isa_pkg::REG_W-1:0] i_rs2_early,
  input  logic [XLEN-1:0]              i_rf_rs1_data,
  input  logic [XLEN-1:0]              i_rf_rs2_data,
  input  logic                         i_wb_we,
  input  logic [id_isa_pkg::REG_W-1:0] i_wb_rd,
  input  logic [XLEN-1:0]              i_wb_data,
  id_operand_if.producer               opnd
);
  logic wb_live;
  logic byp_rs1;
  logic byp_rs2;

  // Write-back lands in the file this cycle while the async read still sees old data
  assign wb_live = i_wb_we && (i_wb_rd != '0);
  assign byp_rs1 = wb_live && (i_wb_rd == i_rs1_early);
  assign byp_rs2 = wb_live && (i_wb_rd == i_rs2_early);

  assign opnd.rs1_data = byp_rs1 ? i_wb_data : i_rf_rs1_data;
  assign opnd.rs2_data = byp_rs2 ? i_wb_data : i_rf_rs2_data;

  // Registered so the forwarding unit in EX skips the compare
  assign opnd.rs1_is_x0 = (i_rs1_early == '0);
  assign opnd.rs2_is_x0 = (i_rs2_early == '0);

  // A write-back to x0 must never reach either operand
  always_comb begin
    if (i_wb_rd == '0) begin
      assert final ((opnd.rs1_data == i_rf_rs1_data) && (opnd.rs2_data == i_rf_rs2_data))
        else $error("id_operand_bypass: bypass selected for x0");
    end
  end

endmodule

`default_nettype wire

// ==== rtl/id_ex_register.sv ====
`default_nettype none

module id_ex_register #(
  parameter int unsigned XLEN = 32
) (
  input  logic                         i_clk,
  input  logic                         i_rst_n,
  input  logic                         i_stall,
  input  logic                         i_flush,
  input  id_isa_pkg::instr_u           i_instr,
  input  logic [XLEN-1:0]              i_pc,
  id_decode_if.consumer                dec,
  id_operand_if.consumer               opnd,
  output logic [31:0]                  o_instr,
  output logic [XLEN-1:0]              o_pc,
  output id_pipe_pkg::id_ctrl_t        o_ctrl,
  output logic [11:0]                  o_csr_addr,
  output logic [id_isa_pkg::REG_W-1:0] o_csr_imm,
  output id_pipe_pkg::id_imm_t         o_imm,
  output logic [XLEN-1:0]              o_branch_target,
  output logic [XLEN-1:0]              o_jal_target,
  output logic [XLEN-1:0]              o_rs1_data,
  output logic [XLEN-1:0]              o_rs2_data,
  output logic                         o_rs1_is_x0,
  output logic                         o_rs2_is_x0
);
  import id_isa_pkg::*;
  import id_pipe_pkg::*;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      // Pipe starts out holding a bubble
      o_instr         <= NOP_INSTR;
      o_ctrl          <= CTRL_NOP;
      o_pc            <= '0;
      o_csr_addr      <= '0;
      o_csr_imm       <= '0;
      o_imm           <= '0;
      o_branch_target <= '0;
      o_jal_target    <= '0;
      o_rs1_data      <= '0;
      o_rs2_data      <= '0;
      // The NOP reads x0 on both ports
      o_rs1_is_x0     <= 1'b1;
      o_rs2_is_x0     <= 1'b1;
    end else if (!i_stall) begin
      // Flush kills the instruction and its control only
      o_instr         <= i_flush ? NOP_INSTR : i_instr;
      o_ctrl          <= i_flush ? CTRL_NOP : dec.ctrl;
      // Datapath keeps loading, harmless under a NOP
      o_pc            <= i_pc;
      o_csr_addr      <= i_instr.sys.csr;
      o_csr_imm       <= i_instr.sys.rs1;
      o_imm           <= dec.imm;
      o_branch_target <= dec.branch_target;
      o_jal_target    <= dec.jal_target;
      o_rs1_data      <= opnd.rs1_data;
      o_rs2_data      <= opnd.rs2_data;
      o_rs1_is_x0     <= opnd.rs1_is_x0;
      o_rs2_is_x0     <= opnd.rs2_is_x0;
    end
  end

  // A flushed slot must reach EX as a clean bubble
  a_flush_bubble: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    (i_flush && !i_stall) |=> (o_ctrl == CTRL_NOP) && (o_instr == NOP_INSTR)
  ) else $error("id_ex_register: flush left control active");

  // Stall wins over flush and freezes the slot
  a_stall_hold: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    i_stall |=> $stable(o_instr)
  ) else $error("id_ex_register: instruction changed under stall");

endmodule

`default_nettype wire

// ==== rtl/id_stage.sv ====
`default_nettype none

module id_stage #(
  parameter int unsigned XLEN = 32
) (
  input  logic                         i_clk,
  input  logic                         i_rst_n,
  input  logic                         i_stall,
  input  logic                         i_flush,
  input  logic [31:0]                  i_instr,
  input  logic [XLEN-1:0]              i_pc,
  input  logic [id_isa_pkg::REG_W-1:0] i_rs1_early,
  input  logic [id_isa_pkg::REG_W-1:0] i_rs2_early,
  input  logic [XLEN-1:0]              i_rf_rs1_data,
  input  logic [XLEN-1:0]              i_rf_rs2_data,
  input  logic                         i_wb_we,
  input  logic [id_isa_pkg::REG_W-1:0] i_wb_rd,
  input  logic [XLEN-1:0]              i_wb_data,
  output logic [31:0]                  o_instr,
  output logic [XLEN-1:0]              o_pc,
  output logic                         o_is_load,
  output logic                         o_is_load_byte,
  output logic                         o_is_load_half,
  output logic                         o_is_load_unsigned,
  output logic                         o_is_mul,
  output logic                         o_is_div,
  output logic                         o_is_jal,
  output logic                         o_is_jalr,
  output logic                         o_is_csr,
  output logic [11:0]                  o_csr_addr,
  output logic [id_isa_pkg::REG_W-1:0] o_csr_imm,
  output logic                         o_is_ecall,
  output logic                         o_is_ebreak,
  output logic                         o_is_mret,
  output logic                         o_is_wfi,
  output logic [2:0]                   o_branch_op,
  output logic [1:0]                   o_store_op,
  output logic [31:0]                  o_imm_i,
  output logic [31:0]                  o_imm_s,
  output logic [31:0]                  o_imm_b,
  output logic [31:0]                  o_imm_u,
  output logic [31:0]                  o_imm_j,
  output logic [XLEN-1:0]              o_branch_target,
  output logic [XLEN-1:0]              o_jal_target,
  output logic [XLEN-1:0]              o_rs1_data,
  output logic [XLEN-1:0]              o_rs2_data,
  output logic                         o_rs1_is_x0,
  output logic                         o_rs2_is_x0
);
  import id_pipe_pkg::*;

  id_ctrl_t ex_ctrl;
  id_imm_t  ex_imm;

  // Decoder to register
  id_decode_if #(.XLEN(XLEN)) dec_if ();
  // Bypass to register
  id_operand_if #(.XLEN(XLEN)) opnd_if ();

  id_decoder #(
    .XLEN (XLEN)
  ) u_decoder (
    .i_instr (i_instr),
    .i_pc    (i_pc),
    .dec     (dec_if.producer)
  );

  id_operand_bypass #(
    .XLEN (XLEN)
  ) u_operand_bypass (
    .i_rs1_early   (i_rs1_early),
    .i_rs2_early   (i_rs2_early),
    .i_rf_rs1_data (i_rf_rs1_data),
    .i_rf_rs2_data (i_rf_rs2_data),
    .i_wb_we       (i_wb_we),
    .i_wb_rd       (i_wb_rd),
    .i_wb_data     (i_wb_data),
    .opnd          (opnd_if.producer)
  );

  id_ex_register #(
    .XLEN (XLEN)
  ) u_ex_register (
    .i_clk           (i_clk),
    .i_rst_n         (i_rst_n),
    .i_stall         (i_stall),
    .i_flush         (i_flush),
    .i_instr         (i_instr),
    .i_pc            (i_pc),
    .dec             (dec_if.consumer),
    .opnd            (opnd_if.consumer),
    .o_instr         (o_instr),
    .o_pc            (o_pc),
    .o_ctrl          (ex_ctrl),
    .o_csr_addr      (o_csr_addr),
    .o_csr_imm       (o_csr_imm),
    .o_imm           (ex_imm),
    .o_branch_target (o_branch_target),
    .o_jal_target    (o_jal_target),
    .o_rs1_data      (o_rs1_data),
    .o_rs2_data      (o_rs2_data),
    .o_rs1_is_x0     (o_rs1_is_x0),
    .o_rs2_is_x0     (o_rs2_is_x0)
  );

  // Control bundle out to flat ports
  assign o_is_load          = ex_ctrl.is_load;
  assign o_is_load_byte     = ex_ctrl.is_load_byte;
  assign o_is_load_half     = ex_ctrl.is_load_half;
  assign o_is_load_unsigned = ex_ctrl.is_load_unsigned;
  assign o_is_mul           = ex_ctrl.is_mul;
  assign o_is_div           = ex_ctrl.is_div;
  assign o_is_jal           = ex_ctrl.is_jal;
  assign o_is_jalr          = ex_ctrl.is_jalr;
  assign o_is_csr           = ex_ctrl.is_csr;
  assign o_is_ecall         = ex_ctrl.is_ecall;
  assign o_is_ebreak        = ex_ctrl.is_ebreak;
  assign o_is_mret          = ex_ctrl.is_mret;
  assign o_is_wfi           = ex_ctrl.is_wfi;
  assign o_branch_op        = ex_ctrl.branch_op;
  assign o_store_op         = ex_ctrl.store_op;

  // Immediates out to flat ports
  assign o_imm_i = ex_imm.imm_i;
  assign o_imm_s = ex_imm.imm_s;
  assign o_imm_b = ex_imm.imm_b;
  assign o_imm_u = ex_imm.imm_u;
  assign o_imm_j = ex_imm.imm_j;

endmodule

`default_nettype wire

// ==== tests/tb_id_model.svh ====
`ifndef TB_ID_MODEL_SVH
`define TB_ID_MODEL_SVH

// Load group {is_load, byte, half, unsigned}
function automatic logic [3:0] model_load(input logic [31:0] w);
  logic       ld;
  logic [2:0] f3;
  ld = (w[6:0] == OPC_LOAD);
  f3 = w[14:12];
  return {ld, ld && (f3 == 3'b000 || f3 == 3'b100), ld && (f3 == 3'b001 || f3 == 3'b101),
          ld && f3[2]};
endfunction

// M extension {is_mul, is_div}
function automatic logic [1:0] model_muldiv(input logic [31:0] w);
  logic m;
  m = (w[6:0] == OPC_OP) && (w[31:25] == FUNCT7_MULDIV);
  return {m && !w[14], m && w[14]};
endfunction

// Jumps {is_jal, is_jalr}
function automatic logic [1:0] model_jump(input logic [31:0] w);
  return {w[6:0] == OPC_JAL, (w[6:0] == OPC_JALR) && (w[14:12] == 3'b000)};
endfunction

// SYSTEM group {is_csr, ecall, ebreak, mret, wfi}, keyed on funct7 and rs2
function automatic logic [4:0] model_sys(input logic [31:0] w);
  logic sys;
  logic priv;
  sys  = (w[6:0] == OPC_SYSTEM);
  priv = sys && (w[14:12] == 3'b000);
  return {sys && (w[14:12] != 3'b000), priv && (w[31:20] == 12'h000),
          priv && (w[31:20] == 12'h001), priv && (w[31:20] == 12'h302),
          priv && (w[31:20] == 12'h105)};
endfunction

function automatic logic [2:0] model_branch(input logic [31:0] w);
  if (w[6:0] != OPC_BRANCH) return BR_NONE;
  case (w[14:12])
    3'b000:  return BR_EQ;
    3'b001:  return BR_NE;
    3'b100:  return BR_LT;
    3'b101:  return BR_GE;
    3'b110:  return BR_LTU;
    3'b111:  return BR_GEU;
    default: return BR_NONE;
  endcase
endfunction

function automatic logic [1:0] model_store(input logic [31:0] w);
  if (w[6:0] != OPC_STORE) return ST_NONE;
  case (w[14:12])
    3'b000:  return ST_BYTE;
    3'b001:  return ST_HALF;
    3'b010:  return ST_WORD;
    default: return ST_NONE;
  endcase
endfunction

// Immediates packed as {i, s, b, u, j}
function automatic logic [159:0] model_imm(input logic [31:0] w);
  logic signed [11:0] ioff;
  logic signed [11:0] soff;
  logic signed [12:0] boff;
  logic signed [20:0] joff;
  ioff = w[31:20];
  soff = {w[31:25], w[11:7]};
  boff = {w[31], w[7], w[30:25], w[11:8], 1'b0};
  joff = {w[31], w[19:12], w[20], w[30:21], 1'b0};
  return {32'(ioff), 32'(soff), 32'(boff), w[31:12], 12'h000, 32'(joff)};
endfunction

// Write-back bypass, never for x0
function automatic logic [XLEN-1:0] model_operand(input logic [4:0] src,
    input logic [XLEN-1:0] rf, input logic we, input logic [4:0] rd,
    input logic [XLEN-1:0] wb);
  return (we && rd != 5'd0 && rd == src) ? wb : rf;
endfunction

`endif

// ==== tests/tb_id_stage.sv ====
`default_nettype none

module tb_id_stage;
  timeunit 1ns;
  timeprecision 1ps;
  import id_isa_pkg::*;

  localparam int XLEN          = 32;
  localparam int NUM_CYCLES    = 3000;
  localparam int RESET_TIMEOUT = 20;

  logic            i_clk, i_rst_n, i_stall, i_flush, i_wb_we;
  logic [31:0]     i_instr;
  logic [XLEN-1:0] i_pc, i_rf_rs1_data, i_rf_rs2_data, i_wb_data;
  logic [4:0]      i_rs1_early, i_rs2_early, i_wb_rd;
  logic [31:0]     o_instr, o_imm_i, o_imm_s, o_imm_b, o_imm_u, o_imm_j;
  logic [XLEN-1:0] o_pc, o_branch_target, o_jal_target, o_rs1_data, o_rs2_data;
  logic            o_is_load, o_is_load_byte, o_is_load_half, o_is_load_unsigned;
  logic            o_is_mul, o_is_div, o_is_jal, o_is_jalr, o_is_csr;
  logic            o_is_ecall, o_is_ebreak, o_is_mret, o_is_wfi;
  logic            o_rs1_is_x0, o_rs2_is_x0;
  logic [11:0]     o_csr_addr;
  logic [4:0]      o_csr_imm;
  logic [2:0]      o_branch_op;
  logic [1:0]      o_store_op;

  // Expected copy of every registered output
  logic [31:0]     exp_instr;
  logic [XLEN-1:0] exp_pc, exp_br_tgt, exp_jal_tgt, exp_rs1, exp_rs2;
  logic [17:0]     exp_ctrl;
  logic [16:0]     exp_csr;
  logic [159:0]    exp_imm;
  logic [1:0]      exp_x0;

  integer seed;
  integer errors;
  integer checks;
  integer wait_cycles;

  `include "tb_id_model.svh"

  id_stage #(.XLEN(XLEN)) dut0 (.*);

  initial begin
    i_clk = 1'b0;
    forever #10 i_clk = ~i_clk;
  end

  // Reset held for two rising edges
  initial begin
    i_rst_n = 1'b0;
    repeat (2) @(posedge i_clk);
    i_rst_n <= 1'b1;
  end

  task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    checks++;
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t: %s got %0h expected %0h", $time, what, actual, expected);
      errors++;
    end
  endtask

  // Bubble with zeroed datapath, both sources read x0
  task automatic load_reset_expect;
    exp_instr   = NOP_INSTR;
    exp_ctrl    = {13'b0, BR_NONE, ST_NONE};
    exp_pc      = '0;
    exp_csr     = '0;
    exp_imm     = '0;
    exp_br_tgt  = '0;
    exp_jal_tgt = '0;
    exp_rs1     = '0;
    exp_rs2     = '0;
    exp_x0      = 2'b11;
  endtask

  // Called at a rising edge before new inputs land, so it sees what the DUT samples
  task automatic update_expect;
    logic [31:0] w;
    w = i_instr;
    if (!i_stall) begin
      exp_imm     = model_imm(w);
      exp_instr   = i_flush ? NOP_INSTR : w;
      exp_ctrl    = i_flush ? {13'b0, BR_NONE, ST_NONE} :
                    {model_load(w), model_muldiv(w), model_jump(w), model_sys(w),
                     model_branch(w), model_store(w)};
      exp_pc      = i_pc;
      exp_csr     = {w[31:20], w[19:15]};
      exp_br_tgt  = i_pc + exp_imm[95:64];
      exp_jal_tgt = i_pc + exp_imm[31:0];
      exp_rs1     = model_operand(i_rs1_early, i_rf_rs1_data, i_wb_we, i_wb_rd, i_wb_data);
      exp_rs2     = model_operand(i_rs2_early, i_rf_rs2_data, i_wb_we, i_wb_rd, i_wb_data);
      exp_x0      = {i_rs1_early == 5'd0, i_rs2_early == 5'd0};
    end
  endtask

  // Weighted opcode choice over random fields
  task automatic drive_random;
    logic [31:0] w;
    logic [4:0]  rd;
    w = $random(seed);
    case ($unsigned($random(seed)) % 16)
      0, 1:    w[6:0] = OPC_LOAD;
      2:       w[6:0] = OPC_STORE;
      3, 4:    w[6:0] = OPC_BRANCH;
      5:       w[6:0] = OPC_JAL;
      6: begin
        w[6:0] = OPC_JALR;
        if ($unsigned($random(seed)) % 4 != 0) w[14:12] = 3'b000;
      end
      7, 8: begin
        w[6:0]   = OPC_OP;
        w[31:25] = FUNCT7_MULDIV;
      end
      9:       w[6:0] = OPC_OP;
      10, 11: begin
        // ECALL, EBREAK, MRET, WFI or an unknown privileged word
        w[6:0]   = OPC_SYSTEM;
        w[14:12] = 3'b000;
        case ($unsigned($random(seed)) % 5)
          0:       w[31:20] = 12'h000;
          1:       w[31:20] = 12'h001;
          2:       w[31:20] = 12'h302;
          3:       w[31:20] = 12'h105;
          default: w[31:20] = w[31:20];
        endcase
      end
      12, 13:  w[6:0] = OPC_SYSTEM;
      14:      w[6:0] = OPC_LUI;
      default: w[6:0] = w[6:0];
    endcase
    if ($unsigned($random(seed)) % 8 == 0) w[19:15] = 5'd0;
    // Write-back register often hits a source
    case ($unsigned($random(seed)) % 4)
      0:       rd = w[19:15];
      1:       rd = w[24:20];
      2:       rd = 5'd0;
      default: rd = $random(seed);
    endcase
    i_instr       <= w;
    i_pc          <= $random(seed) & 32'hffff_fffc;
    i_rs1_early   <= w[19:15];
    i_rs2_early   <= w[24:20];
    i_rf_rs1_data <= $random(seed);
    i_rf_rs2_data <= $random(seed);
    i_wb_we       <= $random(seed);
    i_wb_rd       <= rd;
    i_wb_data     <= $random(seed);
    i_stall       <= ($unsigned($random(seed)) % 6) == 0;
    i_flush       <= ($unsigned($random(seed)) % 6) == 0;
  endtask

  task automatic check_outputs;
    check_value(o_instr, exp_instr, "instr");
    check_value(o_pc, exp_pc, "pc");
    check_value({o_is_load, o_is_load_byte, o_is_load_half, o_is_load_unsigned, o_is_mul,
                 o_is_div, o_is_jal, o_is_jalr, o_is_csr, o_is_ecall, o_is_ebreak,
                 o_is_mret, o_is_wfi, o_branch_op, o_store_op}, exp_ctrl, "control flags");
    check_value({o_csr_addr, o_csr_imm}, exp_csr, "csr addr and imm");
    check_value(o_imm_i, exp_imm[159:128], "imm_i");
    check_value(o_imm_s, exp_imm[127:96], "imm_s");
    check_value(o_imm_b, exp_imm[95:64], "imm_b");
    check_value(o_imm_u, exp_imm[63:32], "imm_u");
    check_value(o_imm_j, exp_imm[31:0], "imm_j");
    check_value(o_branch_target, exp_br_tgt, "branch target");
    check_value(o_jal_target, exp_jal_tgt, "jal target");
    check_value(o_rs1_data, exp_rs1, "rs1 data");
    check_value(o_rs2_data, exp_rs2, "rs2 data");
    check_value({o_rs1_is_x0, o_rs2_is_x0}, exp_x0, "x0 flags");
  endtask

  initial begin
    seed          = 32'h7a30;
    errors        = 0;
    checks        = 0;
    wait_cycles   = 0;
    i_stall       = 1'b0;
    i_flush       = 1'b0;
    i_instr       = '0;
    i_pc          = '0;
    i_rs1_early   = '0;
    i_rs2_early   = '0;
    i_rf_rs1_data = '0;
    i_rf_rs2_data = '0;
    i_wb_we       = 1'b0;
    i_wb_rd       = '0;
    i_wb_data     = '0;
    load_reset_expect();
    // Reset values checked during reset and once after release
    do begin
      @(negedge i_clk);
      check_outputs();
      wait_cycles++;
    end while (!i_rst_n && wait_cycles < RESET_TIMEOUT);
    if (!i_rst_n) begin
      $display("Reset was not released within %0d cycles", RESET_TIMEOUT);
      errors++;
    end else begin
      for (int cycle = 0; cycle < NUM_CYCLES; cycle++) begin
        @(posedge i_clk);
        update_expect();
        drive_random();
        @(negedge i_clk);
        check_outputs();
      end
    end
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+tests
rtl/id_isa_pkg.sv
rtl/id_pipe_pkg.sv
rtl/id_decode_if.sv
rtl/id_operand_if.sv
rtl/id_decoder.sv
rtl/id_operand_bypass.sv
rtl/id_ex_register.sv
rtl/id_stage.sv
tests/tb_id_stage.sv
